/* logic/csr_params.svh */
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Data and address widths.
`define CSR_XLEN 32
`define CSR_ADDR_W 12

// Request FIFO depth, also the core's request credits after reset.
`define CSR_REQ_DEPTH 4

// Response credits held by the unit after reset.
`define CSR_RESP_CREDITS 2

// MXL = 1 (32 bit), extension I only.
`define CSR_MISA_VALUE 32'h4000_0100

`endif

/* logic/csr_pkg.sv */
`include "csr_params.svh"

package csr_pkg;

  typedef logic [`CSR_XLEN-1:0] csr_data_t;
  typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [3:0] csr_cause_t;

  typedef enum logic {
    CSR_OP_READ = 1'b0,
    CSR_OP_SWAP = 1'b1
  } csr_op_e;

  localparam csr_addr_t CSR_MSTATUS    = 12'h300;
  localparam csr_addr_t CSR_MISA       = 12'h301;
  localparam csr_addr_t CSR_MEDELEG    = 12'h302;
  localparam csr_addr_t CSR_MIDELEG    = 12'h303;
  localparam csr_addr_t CSR_MIE        = 12'h304;
  localparam csr_addr_t CSR_MTVEC      = 12'h305;
  localparam csr_addr_t CSR_MCOUNTEREN = 12'h306;
  localparam csr_addr_t CSR_MSCRATCH   = 12'h340;
  localparam csr_addr_t CSR_MEPC       = 12'h341;
  localparam csr_addr_t CSR_MCAUSE     = 12'h342;
  localparam csr_addr_t CSR_MTVAL      = 12'h343;
  localparam csr_addr_t CSR_MIP        = 12'h344;
  localparam csr_addr_t CSR_MCYCLE     = 12'hB00;
  localparam csr_addr_t CSR_MINSTRET   = 12'hB02;
  localparam csr_addr_t CSR_MCYCLEH    = 12'hB80;
  localparam csr_addr_t CSR_MINSTRETH  = 12'hB82;

  // mstatus bit positions.
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;

  typedef struct packed {
    csr_op_e   op;
    csr_addr_t addr;
    csr_data_t wdata;
  } csr_req_t;

  typedef struct packed {
    csr_data_t rdata;
    logic      hit;
  } csr_resp_t;

  typedef struct packed {
    logic       exception;
    logic       mret;
    logic       retire;
    csr_data_t  epc;
    csr_data_t  tval;
    csr_cause_t cause;
  } trap_in_t;

  typedef struct packed {
    logic      valid;
    csr_data_t target;
  } redirect_t;

  typedef struct packed {
    logic     valid;
    csr_req_t req;
  } csr_issue_t;

endpackage

/* logic/csr_req_queue.sv */
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_req_queue
  import csr_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       req_valid,
  input  csr_req_t   req,
  input  logic       resp_credit,
  output logic       req_credit,
  output csr_issue_t issue
);

  csr_req_t mem [`CSR_REQ_DEPTH];

  logic [$clog2(`CSR_REQ_DEPTH)-1:0]      wr_ptr;
  logic [$clog2(`CSR_REQ_DEPTH)-1:0]      rd_ptr;
  logic [$clog2(`CSR_REQ_DEPTH+1)-1:0]    count;
  logic [$clog2(`CSR_RESP_CREDITS+1)-1:0] credits;
  logic                                   pop;

  // Head leaves only when a response slot is guaranteed downstream.
  assign pop = (count != '0) && (credits != '0);

  assign issue.valid = pop;
  assign issue.req   = mem[rd_ptr];
  assign req_credit  = pop;

  always_ff @(posedge clk) begin
    if (req_valid) begin
      mem[wr_ptr] <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= ($bits(credits))'(`CSR_RESP_CREDITS);
    end else begin
      if (req_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      case ({req_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      case ({resp_credit, pop})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

/* logic/csr_trap_regs.sv */
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_trap_regs
  import csr_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  csr_issue_t issue,
  input  trap_in_t   trap,
  output csr_data_t  rdata,
  output logic       hit,
  output csr_data_t  mtvec,
  output csr_data_t  mcause,
  output csr_data_t  mepc,
  output logic       took_exception,
  output logic       took_mret
);

  csr_data_t mstatus_q;
  csr_data_t medeleg_q;
  csr_data_t mideleg_q;
  csr_data_t mie_q;
  csr_data_t mtvec_q;
  csr_data_t mcounteren_q;
  csr_data_t mscratch_q;
  csr_data_t mepc_q;
  csr_data_t mcause_q;
  csr_data_t mtval_q;
  csr_data_t mip_q;
  logic      swap;

  assign swap   = issue.valid && (issue.req.op == CSR_OP_SWAP);
  assign mtvec  = mtvec_q;
  assign mcause = mcause_q;
  assign mepc   = mepc_q;

  always_comb begin
    hit = 1'b1;
    case (issue.req.addr)
      CSR_MSTATUS:    rdata = mstatus_q;
      CSR_MISA:       rdata = `CSR_MISA_VALUE;
      CSR_MEDELEG:    rdata = medeleg_q;
      CSR_MIDELEG:    rdata = mideleg_q;
      CSR_MIE:        rdata = mie_q;
      CSR_MTVEC:      rdata = mtvec_q;
      CSR_MCOUNTEREN: rdata = mcounteren_q;
      CSR_MSCRATCH:   rdata = mscratch_q;
      CSR_MEPC:       rdata = mepc_q;
      CSR_MCAUSE:     rdata = mcause_q;
      CSR_MTVAL:      rdata = mtval_q;
      CSR_MIP:        rdata = mip_q;
      default: begin
        rdata = '0;
        hit   = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      mstatus_q      <= '0;
      medeleg_q      <= '0;
      mideleg_q      <= '0;
      mie_q          <= '0;
      mtvec_q        <= '0;
      mcounteren_q   <= '0;
      mscratch_q     <= '0;
      mepc_q         <= '0;
      mcause_q       <= '0;
      mtval_q        <= '0;
      mip_q          <= '0;
      took_exception <= 1'b0;
      took_mret      <= 1'b0;
    end else begin
      // misa writes are dropped.
      if (swap) begin
        case (issue.req.addr)
          CSR_MSTATUS:    mstatus_q    <= issue.req.wdata;
          CSR_MEDELEG:    medeleg_q    <= issue.req.wdata;
          CSR_MIDELEG:    mideleg_q    <= issue.req.wdata;
          CSR_MIE:        mie_q        <= issue.req.wdata;
          CSR_MTVEC:      mtvec_q      <= issue.req.wdata;
          CSR_MCOUNTEREN: mcounteren_q <= issue.req.wdata;
          CSR_MSCRATCH:   mscratch_q   <= issue.req.wdata;
          CSR_MEPC:       mepc_q       <= issue.req.wdata;
          CSR_MCAUSE:     mcause_q     <= issue.req.wdata;
          CSR_MTVAL:      mtval_q      <= issue.req.wdata;
          CSR_MIP:        mip_q        <= issue.req.wdata;
          default: ;
        endcase
      end

      // Trap updates come last so they override a swap in the same cycle.
      if (trap.exception) begin
        mstatus_q[MSTATUS_MPIE] <= mstatus_q[MSTATUS_MIE];
        mstatus_q[MSTATUS_MIE]  <= 1'b0;
        mepc_q                  <= trap.epc;
        mtval_q                 <= trap.tval;
        mcause_q                <= {{(`CSR_XLEN-4){1'b0}}, trap.cause};
      end else if (trap.mret) begin
        mstatus_q[MSTATUS_MIE]  <= mstatus_q[MSTATUS_MPIE];
        mstatus_q[MSTATUS_MPIE] <= 1'b0;
      end

      took_exception <= trap.exception;
      took_mret      <= trap.mret && !trap.exception;
    end
  end

endmodule

/* logic/csr_counters.sv */
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_counters
  import csr_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  csr_issue_t issue,
  input  logic       retire,
  output csr_data_t  rdata,
  output logic       hit
);

  logic [2*`CSR_XLEN-1:0] mcycle_q;
  logic [2*`CSR_XLEN-1:0] minstret_q;
  logic                   swap;

  // A half write replaces the increment for that cycle.
  function automatic logic [2*`CSR_XLEN-1:0] cnt_next(
    input logic [2*`CSR_XLEN-1:0] cur,
    input logic                   wr_lo,
    input logic                   wr_hi,
    input csr_data_t              wdata,
    input logic                   inc
  );
    if (wr_lo) begin
      return {cur[2*`CSR_XLEN-1:`CSR_XLEN], wdata};
    end else if (wr_hi) begin
      return {wdata, cur[`CSR_XLEN-1:0]};
    end else begin
      return cur + {{(2*`CSR_XLEN-1){1'b0}}, inc};
    end
  endfunction

  assign swap = issue.valid && (issue.req.op == CSR_OP_SWAP);

  always_comb begin
    hit = 1'b1;
    case (issue.req.addr)
      CSR_MCYCLE:    rdata = mcycle_q[`CSR_XLEN-1:0];
      CSR_MCYCLEH:   rdata = mcycle_q[2*`CSR_XLEN-1:`CSR_XLEN];
      CSR_MINSTRET:  rdata = minstret_q[`CSR_XLEN-1:0];
      CSR_MINSTRETH: rdata = minstret_q[2*`CSR_XLEN-1:`CSR_XLEN];
      default: begin
        rdata = '0;
        hit   = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
    end else begin
      mcycle_q <= cnt_next(mcycle_q,
                           swap && (issue.req.addr == CSR_MCYCLE),
                           swap && (issue.req.addr == CSR_MCYCLEH),
                           issue.req.wdata, 1'b1);
      minstret_q <= cnt_next(minstret_q,
                             swap && (issue.req.addr == CSR_MINSTRET),
                             swap && (issue.req.addr == CSR_MINSTRETH),
                             issue.req.wdata, retire);
    end
  end

endmodule

/* logic/csr_read_merge.sv */
`timescale 1ns/1ps

module csr_read_merge
  import csr_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  csr_issue_t issue,
  input  csr_data_t  trap_rdata,
  input  logic       trap_hit,
  input  csr_data_t  cnt_rdata,
  input  logic       cnt_hit,
  input  csr_data_t  mtvec,
  input  csr_data_t  mcause,
  input  csr_data_t  mepc,
  input  logic       took_exception,
  input  logic       took_mret,
  output logic       resp_valid,
  output csr_resp_t  resp,
  output redirect_t  redirect
);

  csr_resp_t sel;
  csr_data_t trap_base;
  csr_data_t trap_target;

  always_comb begin
    if (trap_hit) begin
      sel = '{rdata: trap_rdata, hit: 1'b1};
    end else if (cnt_hit) begin
      sel = '{rdata: cnt_rdata, hit: 1'b1};
    end else begin
      sel = '{rdata: '0, hit: 1'b0};
    end
  end

  // Vectored mode adds four times the cause to the base.
  assign trap_base   = {mtvec[31:2], 2'b00};
  assign trap_target = (mtvec[1:0] == 2'd1) ?
                       trap_base + {26'b0, mcause[3:0], 2'b00} : trap_base;

  assign redirect.valid  = took_exception || took_mret;
  assign redirect.target = took_exception ? trap_target : mepc;

  always_ff @(posedge clk) begin
    if (issue.valid) begin
      resp <= sel;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= issue.valid;
    end
  end

endmodule

/* logic/csr_unit.sv */
`timescale 1ns/1ps

module csr_unit
  import csr_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      req_valid,
  input  csr_req_t  req,
  output logic      req_credit,
  input  logic      resp_credit,
  output logic      resp_valid,
  output csr_resp_t resp,
  input  trap_in_t  trap,
  output redirect_t redirect
);

  csr_issue_t issue;
  csr_data_t  trap_rdata;
  logic       trap_hit;
  csr_data_t  cnt_rdata;
  logic       cnt_hit;
  csr_data_t  mtvec;
  csr_data_t  mcause;
  csr_data_t  mepc;
  logic       took_exception;
  logic       took_mret;

  csr_req_queue csr_req_queue_i (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req         (req),
    .resp_credit (resp_credit),
    .req_credit  (req_credit),
    .issue       (issue)
  );

  csr_trap_regs csr_trap_regs_i (
    .clk            (clk),
    .rst            (rst),
    .issue          (issue),
    .trap           (trap),
    .rdata          (trap_rdata),
    .hit            (trap_hit),
    .mtvec          (mtvec),
    .mcause         (mcause),
    .mepc           (mepc),
    .took_exception (took_exception),
    .took_mret      (took_mret)
  );

  csr_counters csr_counters_i (
    .clk    (clk),
    .rst    (rst),
    .issue  (issue),
    .retire (trap.retire),
    .rdata  (cnt_rdata),
    .hit    (cnt_hit)
  );

  csr_read_merge csr_read_merge_i (
    .clk            (clk),
    .rst            (rst),
    .issue          (issue),
    .trap_rdata     (trap_rdata),
    .trap_hit       (trap_hit),
    .cnt_rdata      (cnt_rdata),
    .cnt_hit        (cnt_hit),
    .mtvec          (mtvec),
    .mcause         (mcause),
    .mepc           (mepc),
    .took_exception (took_exception),
    .took_mret      (took_mret),
    .resp_valid     (resp_valid),
    .resp           (resp),
    .redirect       (redirect)
  );

endmodule

/* tb/csr_unit_properties.sv */
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_unit_properties
  import csr_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      req_valid,
  input logic      req_credit,
  input logic      resp_credit,
  input logic      resp_valid,
  input redirect_t redirect,
  input trap_in_t  trap
);

  int   held;
  int   entries;
  int   failures = 0;
  logic in_reset_q;

  // Credits seen from the response side, and entries waiting in the FIFO.
  always_ff @(posedge clk) begin
    if (!rst) begin
      held    <= `CSR_RESP_CREDITS;
      entries <= 0;
    end else begin
      held    <= held - int'(resp_valid) + int'(resp_credit);
      entries <= entries + int'(req_valid) - int'(req_credit);
    end
  end

  always_ff @(posedge clk) begin
    in_reset_q <= !rst;
  end

  resp_needs_credit: assert property (@(posedge clk) disable iff (!rst)
    resp_valid |-> held > 0)
    else begin
      $error("resp_valid fired with no response credit held");
      failures++;
    end

  credit_per_entry: assert property (@(posedge clk) disable iff (!rst)
    req_credit |-> entries > 0)
    else begin
      $error("req_credit fired with no entry left in the FIFO");
      failures++;
    end

  redirect_one_cycle: assert property (@(posedge clk) disable iff (!rst)
    redirect.valid |=> !redirect.valid)
    else begin
      $error("redirect.valid held for more than one cycle");
      failures++;
    end

  // The redirect comes one cycle after the exception or mret input.
  redirect_follows_trap: assert property (@(posedge clk) disable iff (!rst)
    redirect.valid == $past(trap.exception || trap.mret))
    else begin
      $error("redirect.valid does not follow the exception or mret of the cycle before");
      failures++;
    end

  quiet_in_reset: assert property (@(posedge clk)
    (!rst && in_reset_q) |-> (!resp_valid && !req_credit && !redirect.valid))
    else begin
      $error("Outputs active during reset");
      failures++;
    end

endmodule

bind csr_unit csr_unit_properties csr_unit_properties_i (
  .clk         (clk),
  .rst         (rst),
  .req_valid   (req_valid),
  .req_credit  (req_credit),
  .resp_credit (resp_credit),
  .resp_valid  (resp_valid),
  .redirect    (redirect),
  .trap        (trap)
);

/* tb/csr_unit_tb.sv */
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_unit_tb;
  import csr_pkg::*;

  // Tests take a few hundred cycles, so this leaves wide margin.
  localparam int TIMEOUT_CYCLES = 2000;

  typedef struct packed {
    logic      check_data;
    csr_data_t rdata;
    logic      hit;
  } resp_exp_t;

  logic      clk;
  logic      rst;
  logic      req_valid;
  csr_req_t  req;
  logic      req_credit;
  logic      resp_credit;
  logic      resp_valid;
  csr_resp_t resp;
  trap_in_t  trap;
  redirect_t redirect;

  csr_data_t model [0:4095];
  resp_exp_t exp_q [$];
  resp_exp_t head;
  csr_data_t last_rdata;
  csr_data_t seed = 32'd94;
  int        req_credits = `CSR_REQ_DEPTH;
  int        pending_credits = 0;
  logic      hold_credits = 1'b0;
  int        resp_count = 0;
  int        pass_count = 0;
  int        fail_count = 0;
  int        test_base = 0;
  int        cycles = 0;

  csr_addr_t rw_addrs [11] = '{CSR_MSTATUS, CSR_MEDELEG, CSR_MIDELEG, CSR_MIE, CSR_MTVEC,
                               CSR_MCOUNTEREN, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE,
                               CSR_MTVAL, CSR_MIP};

  csr_unit csr_unit_i (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req         (req),
    .req_credit  (req_credit),
    .resp_credit (resp_credit),
    .resp_valid  (resp_valid),
    .resp        (resp),
    .trap        (trap),
    .redirect    (redirect)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  function automatic csr_data_t lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic is_rw(input csr_addr_t addr);
    foreach (rw_addrs[i]) begin
      if (rw_addrs[i] == addr) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  function automatic logic is_counter(input csr_addr_t addr);
    return (addr == CSR_MCYCLE) || (addr == CSR_MCYCLEH) ||
           (addr == CSR_MINSTRET) || (addr == CSR_MINSTRETH);
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_eq(input string name, input csr_data_t exp, input csr_data_t act);
    assert (act === exp) pass_count++;
    else begin
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      fail_count++;
    end
  endtask

  task automatic check_at_least(input string name, input csr_data_t low, input csr_data_t act);
    assert (act >= low) pass_count++;
    else begin
      $display("CHECK FAILED at %0t: %s expected at least %h, got %h", $time, name, low, act);
      fail_count++;
    end
  endtask

  // Responses are compared at the falling edge, when they are stable.
  always @(negedge clk) begin
    if (rst) begin
      if (req_credit) begin
        req_credits++;
      end
      if (resp_valid) begin
        resp_count++;
        pending_credits++;
        last_rdata = resp.rdata;
        if (exp_q.size() == 0) begin
          $display("A response arrived at %0t with no request outstanding", $time);
          fail_count++;
        end else begin
          head = exp_q.pop_front();
          check_eq("resp.hit", 32'(head.hit), 32'(resp.hit));
          if (head.check_data) begin
            check_eq("resp.rdata", head.rdata, resp.rdata);
          end
        end
      end
    end
  end

  // The core returns one response credit per cycle unless it holds them back.
  initial begin
    resp_credit = 1'b0;
    forever begin
      step();
      if (rst && !hold_credits && pending_credits > 0) begin
        resp_credit = 1'b1;
        pending_credits--;
      end else begin
        resp_credit = 1'b0;
      end
    end
  end

  task automatic issue_req(input csr_op_e op, input csr_addr_t addr, input csr_data_t wdata,
                           input resp_exp_t e);
    while (req_credits == 0) begin
      step();
    end
    exp_q.push_back(e);
    req_credits--;
    req_valid = 1'b1;
    req = '{op: op, addr: addr, wdata: wdata};
    step();
    req_valid = 1'b0;
  endtask

  // Expected response follows from the model; counters are left unchecked.
  task automatic csr_access(input csr_op_e op, input csr_addr_t addr, input csr_data_t wdata);
    resp_exp_t e;
    e = '{check_data: 1'b1, rdata: '0, hit: 1'b1};
    if (addr == CSR_MISA) begin
      e.rdata = `CSR_MISA_VALUE;
    end else if (is_rw(addr)) begin
      e.rdata = model[addr];
      if (op == CSR_OP_SWAP) begin
        model[addr] = wdata;
      end
    end else if (is_counter(addr)) begin
      e.check_data = 1'b0;
    end else begin
      e.hit = 1'b0;
    end
    issue_req(op, addr, wdata, e);
  endtask

  task automatic counter_access(input csr_op_e op, input csr_addr_t addr, input csr_data_t wdata,
                                input logic check, input csr_data_t value);
    issue_req(op, addr, wdata, '{check_data: check, rdata: value, hit: 1'b1});
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      step();
    end
  endtask

  task automatic read_counter(input csr_addr_t addr, output csr_data_t value);
    counter_access(CSR_OP_READ, addr, '0, 1'b0, '0);
    drain();
    value = last_rdata;
  endtask

  task automatic pulse_retire(input int n);
    repeat (n) begin
      trap.retire = 1'b1;
      step();
      trap.retire = 1'b0;
      step();
    end
  endtask

  // Exception wins over mret; mstatus follows the MIE and MPIE rules.
  task automatic raise_trap(input logic exc, input logic ret, input csr_cause_t cause,
                            input csr_data_t epc, input csr_data_t tval);
    csr_data_t base;
    csr_data_t target;
    csr_data_t st;
    base = {model[CSR_MTVEC][31:2], 2'b00};
    st   = model[CSR_MSTATUS];
    if (exc) begin
      target = (model[CSR_MTVEC][1:0] == 2'd1) ? base + 32'(cause) * 4 : base;
      st[MSTATUS_MPIE] = st[MSTATUS_MIE];
      st[MSTATUS_MIE]  = 1'b0;
      model[CSR_MEPC]   = epc;
      model[CSR_MTVAL]  = tval;
      model[CSR_MCAUSE] = 32'(cause);
    end else begin
      target = model[CSR_MEPC];
      st[MSTATUS_MIE]  = st[MSTATUS_MPIE];
      st[MSTATUS_MPIE] = 1'b0;
    end
    model[CSR_MSTATUS] = st;
    trap.exception = exc;
    trap.mret      = ret;
    trap.cause     = cause;
    trap.epc       = epc;
    trap.tval      = tval;
    step();
    trap.exception = 1'b0;
    trap.mret      = 1'b0;
    // The redirect is due in the cycle right after the event.
    check_eq("redirect.valid", 32'd1, 32'(redirect.valid));
    if (redirect.valid) begin
      check_eq("redirect.target", target, redirect.target);
    end
    step();
  endtask

  task automatic end_test(input string name);
    $display("%-24s %s", name, (fail_count == test_base) ? "passed" : "failed");
    test_base = fail_count;
  endtask

  task automatic test_trap_regs();
    foreach (rw_addrs[i]) begin
      csr_access(CSR_OP_SWAP, rw_addrs[i], lcg_next());
      csr_access(CSR_OP_READ, rw_addrs[i], '0);
    end
    csr_access(CSR_OP_READ, CSR_MISA, '0);
    csr_access(CSR_OP_SWAP, CSR_MISA, lcg_next());
    csr_access(CSR_OP_READ, CSR_MISA, '0);
    csr_access(CSR_OP_READ, 12'h7C0, '0);
    csr_access(CSR_OP_SWAP, 12'hFFF, lcg_next());
    drain();
    end_test("trap register access");
  endtask

  task automatic test_counters();
    csr_data_t c0;
    csr_data_t c1;
    csr_data_t w;
    read_counter(CSR_MCYCLE, c0);
    repeat (5) begin
      csr_access(CSR_OP_READ, CSR_MSCRATCH, '0);
    end
    drain();
    read_counter(CSR_MCYCLE, c1);
    check_at_least("mcycle", c0 + 5, c1);
    read_counter(CSR_MINSTRET, c0);
    pulse_retire(7);
    read_counter(CSR_MINSTRET, c1);
    check_eq("minstret", c0 + 7, c1);
    w = lcg_next() >> 1;
    counter_access(CSR_OP_SWAP, CSR_MINSTRET, w, 1'b1, c1);
    drain();
    pulse_retire(3);
    counter_access(CSR_OP_READ, CSR_MINSTRET, '0, 1'b1, w + 3);
    w = lcg_next();
    counter_access(CSR_OP_SWAP, CSR_MCYCLEH, w, 1'b1, '0);
    drain();
    counter_access(CSR_OP_READ, CSR_MCYCLEH, '0, 1'b1, w);
    drain();
    end_test("counters");
  endtask

  task automatic test_trap_entry();
    csr_data_t base;
    base = lcg_next() & 32'hFFFF_FFFC;
    csr_access(CSR_OP_SWAP, CSR_MSTATUS, 32'h8);
    csr_access(CSR_OP_SWAP, CSR_MTVEC, base);
    drain();
    raise_trap(1'b1, 1'b0, 4'(lcg_next()), lcg_next(), lcg_next());
    csr_access(CSR_OP_READ, CSR_MEPC, '0);
    csr_access(CSR_OP_READ, CSR_MCAUSE, '0);
    csr_access(CSR_OP_READ, CSR_MTVAL, '0);
    csr_access(CSR_OP_READ, CSR_MSTATUS, '0);
    csr_access(CSR_OP_SWAP, CSR_MTVEC, base | 32'h1);
    drain();
    raise_trap(1'b1, 1'b0, 4'(lcg_next()) | 4'h1, lcg_next(), lcg_next());
    csr_access(CSR_OP_READ, CSR_MCAUSE, '0);
    csr_access(CSR_OP_READ, CSR_MSTATUS, '0);
    drain();
    end_test("trap entry");
  endtask

  task automatic test_trap_return();
    csr_access(CSR_OP_SWAP, CSR_MSTATUS, 32'h8);
    drain();
    raise_trap(1'b1, 1'b0, 4'(lcg_next()), lcg_next(), lcg_next());
    raise_trap(1'b0, 1'b1, '0, '0, '0);
    csr_access(CSR_OP_READ, CSR_MSTATUS, '0);
    drain();
    raise_trap(1'b1, 1'b1, 4'(lcg_next()), lcg_next(), lcg_next());
    csr_access(CSR_OP_READ, CSR_MSTATUS, '0);
    csr_access(CSR_OP_READ, CSR_MEPC, '0);
    drain();
    end_test("trap return");
  endtask

  task automatic test_back_pressure();
    int base_count;
    drain();
    while (pending_credits != 0) begin
      step();
    end
    repeat (2) step();
    hold_credits = 1'b1;
    base_count = resp_count;
    repeat ((`CSR_REQ_DEPTH + `CSR_RESP_CREDITS) / 2) begin
      csr_access(CSR_OP_SWAP, CSR_MSCRATCH, lcg_next());
      csr_access(CSR_OP_READ, CSR_MSCRATCH, '0);
    end
    repeat (10) step();
    check_eq("resp_valid count", `CSR_RESP_CREDITS, resp_count - base_count);
    check_eq("request credits held", 0, req_credits);
    hold_credits = 1'b0;
    drain();
    check_eq("request credits after drain", `CSR_REQ_DEPTH, req_credits);
    end_test("back-pressure");
  endtask

  initial begin
    rst       = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    trap      = '0;
    foreach (model[i]) begin
      model[i] = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b1;
    step();
    test_trap_regs();
    test_counters();
    test_trap_entry();
    test_trap_return();
    test_back_pressure();
    $display("checks passed %0d, checks failed %0d, assertion failures %0d",
             pass_count, fail_count, csr_unit_i.csr_unit_properties_i.failures);
    if (fail_count == 0 && csr_unit_i.csr_unit_properties_i.failures == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+logic
logic/csr_pkg.sv
logic/csr_req_queue.sv
logic/csr_trap_regs.sv
logic/csr_counters.sv
logic/csr_read_merge.sv
logic/csr_unit.sv
tb/csr_unit_properties.sv
tb/csr_unit_tb.sv

/* Makefile */
BIN  := obj_dir/Vcsr_unit_tb
SRCS := $(filter-out +%,$(shell cat list.f)) logic/csr_params.svh

.PHONY: all run clean

all: run

$(BIN): list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module csr_unit_tb -f list.f

run: $(BIN)
	$(BIN) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -qx "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
